// File: build.f
+incdir+hw
hw/wph_pkg.sv
hw/wph_ctrl_if.sv
hw/wph_ctrl_fsm.sv
hw/wph_fill_timer.sv
hw/wph_history_tap.sv
hw/wph_tap_match.sv
hw/wph_top.sv
dv/wph_properties.sv
dv/wph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the write-port history testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module wph_tb -f build.f -o wph_sim

# Assertion errors must not stop the run before the testbench summary
./obj_dir/wph_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx -- '>>> PASS' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: dv/wph_tb.sv
// Write-port history testbench
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_tb;

	// Timer clears one edge after the flush edge, counts to FILL_MAX, then the FSM steps once
	localparam int READY_LAT = `WPH_FILL_MAX + 2;
	// Model ring, one slot deeper than the oldest tap looks back
	localparam int RING = `WPH_DEPTH + 1;
	// Tests take about 830 cycles including reset, the limit leaves headroom
	localparam int TIMEOUT_CYCLES = 1500;

	logic                  clk = 1'b0;
	logic                  rst_n_i;
	wph_pkg::wp_group_t    wp_i;
	logic                  flush_i;
	logic                  query_i;
	logic [`WPH_TAG_W-1:0] query_tag_i;
	logic [`WPH_NTAPS-1:0] hit_o;
	logic                  hit_valid_o;
	logic                  ready_o;

	// Reference model, every recorded group carries the epoch it was written in
	wph_pkg::wp_group_t    m_grp [RING];
	int                    m_epoch [RING];
	int                    epoch = 0;
	int                    edge_cnt = 0;
	int                    since_flush = 0;
	logic [`WPH_NTAPS-1:0] exp_hit = '0;
	logic                  exp_hit_valid = 1'b0;
	int                    multi_hits = 0;

	int                    pass_cnt = 0;
	int                    fail_cnt = 0;
	int                    test_err = 0;
	int                    cycle_cnt = 0;
	logic [31:0]           rng = 32'he719_df29;

	wph_top dut_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.wp_i        (wp_i),
		.flush_i     (flush_i),
		.query_i     (query_i),
		.query_tag_i (query_tag_i),
		.hit_o       (hit_o),
		.hit_valid_o (hit_valid_o),
		.ready_o     (ready_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Simulation timed out after %0d cycles", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ====================
	// Reference model
	// ====================

	function automatic int tap_age(input int k);
		case (k)
			0:       return `WPH_TAP0;
			1:       return `WPH_TAP1;
			2:       return `WPH_TAP2;
			3:       return `WPH_TAP3;
			default: return `WPH_TAP4;
		endcase
	endfunction

	// Tap k at a query edge holds the group sampled tap_age(k)+1 edges earlier
	// A reset edge counts as a flush edge, its group and all older ones are stale
	always @(posedge clk)
	begin
		int s;
		exp_hit = '0;
		exp_hit_valid = rst_n_i && query_i;
		for (int k = 0; k < `WPH_NTAPS; k++)
		begin
			s = edge_cnt - tap_age(k) - 1;
			if (exp_hit_valid && s >= 0 && m_epoch[s % RING] == epoch)
				for (int p = 0; p < `WPH_PORTS; p++)
					if (m_grp[s % RING][p].valid && m_grp[s % RING][p].tag == query_tag_i)
						exp_hit[k] = 1'b1;
		end
		if ($countones(exp_hit) > 1)
			multi_hits++;
		m_grp[edge_cnt % RING] = wp_i;
		m_epoch[edge_cnt % RING] = epoch;
		if (!rst_n_i || flush_i)
		begin
			epoch++;
			since_flush = 0;
		end
		else if (since_flush < READY_LAT)
			since_flush++;
		edge_cnt++;
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Narrow 4-bit tags so that taps collide often
	function automatic wph_pkg::wp_group_t rand_group(input logic [31:0] r);
		wph_pkg::wp_group_t g;
		for (int p = 0; p < `WPH_PORTS; p++)
		begin
			g[p].valid = r[p];
			g[p].tag = `WPH_TAG_W'(r[8 + 4*p +: 4]);
		end
		return g;
	endfunction

	function automatic wph_pkg::wp_group_t one_write(input int port, input logic [7:0] tag);
		wph_pkg::wp_group_t g;
		g = '0;
		g[port].valid = 1'b1;
		g[port].tag = tag;
		return g;
	endfunction

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			fail_cnt++;
			test_err++;
		end
		else
			pass_cnt++;
	endtask

	// Outputs are stable at the falling edge, check them and then drive the next inputs
	task automatic step(input wph_pkg::wp_group_t wp, input logic flush, input logic query,
		input logic [`WPH_TAG_W-1:0] tag);
		@(negedge clk);
		expect_eq(hit_valid_o, exp_hit_valid, "hit_valid_o");
		expect_eq(hit_o, exp_hit, "hit_o");
		expect_eq(ready_o, since_flush >= READY_LAT, "ready_o");
		wp_i = wp;
		flush_i = flush;
		query_i = query;
		query_tag_i = tag;
	endtask

	// Query roughly three cycles out of four
	task automatic random_steps(input int n, input logic flush_first);
		for (int i = 0; i < n; i++)
		begin
			rng = xorshift(rng);
			step(rand_group(rng), flush_first && i == 0, rng[28] | rng[29],
				`WPH_TAG_W'(rng[27:24]));
		end
	endtask

	task automatic close_test(input string name);
		$display("%-20s finished with %0d errors", name, test_err);
		test_err = 0;
	endtask

	// ====================
	// Tests
	// ====================

	task automatic fill_after_reset();
		for (int i = 0; i < READY_LAT + 6; i++)
			step('0, 1'b0, 1'b0, '0);
		expect_eq(ready_o, 1, "ready_o after fill");
		close_test("fill_after_reset");
	endtask

	// One write of a fresh tag, then a query every cycle sees it pass each tap once
	task automatic single_tag_ages();
		int hits [`WPH_NTAPS];
		int seen_at [`WPH_NTAPS];
		for (int k = 0; k < `WPH_NTAPS; k++)
		begin
			hits[k] = 0;
			seen_at[k] = -1;
		end
		step(one_write(2, 8'hA5), 1'b0, 1'b0, '0);
		for (int j = 0; j <= `WPH_TAP4 + 3; j++)
		begin
			step('0, 1'b0, j < `WPH_TAP4 + 3, 8'hA5);
			for (int k = 0; k < `WPH_NTAPS; k++)
				if (hit_valid_o && hit_o[k])
				begin
					hits[k]++;
					seen_at[k] = j;
				end
		end
		// Answer to the query issued in iteration age shows up one iteration later
		for (int k = 0; k < `WPH_NTAPS; k++)
		begin
			expect_eq(hits[k], 1, $sformatf("tap %0d hit count", k));
			expect_eq(seen_at[k], tap_age(k) + 1, $sformatf("tap %0d hit position", k));
		end
		close_test("single_tag_ages");
	endtask

	task automatic random_traffic();
		random_steps(300, 1'b0);
		step('0, 1'b0, 1'b0, '0);
		expect_eq(multi_hits > 0, 1, "multi-tap hits seen");
		close_test("random_traffic");
	endtask

	task automatic flush_mid_stream();
		random_steps(20, 1'b0);
		random_steps(2, 1'b1);
		expect_eq(ready_o, 0, "ready_o after flush");
		random_steps(READY_LAT + 8, 1'b0);
		expect_eq(ready_o, 1, "ready_o after refill");
		close_test("flush_mid_stream");
	endtask

	// Second flush lands while the FSM is still refilling
	task automatic flush_during_fill();
		random_steps(40, 1'b1);
		expect_eq(ready_o, 0, "ready_o during fill");
		random_steps(READY_LAT + 8, 1'b1);
		expect_eq(ready_o, 1, "ready_o after second refill");
		close_test("flush_during_fill");
	endtask

	initial
	begin
		rst_n_i = 1'b0;
		wp_i = '0;
		flush_i = 1'b0;
		query_i = 1'b0;
		query_tag_i = '0;
		repeat (3) @(negedge clk);
		rst_n_i = 1'b1;
		fill_after_reset();
		single_tag_ages();
		random_traffic();
		flush_mid_stream();
		flush_during_fill();
		step('0, 1'b0, 1'b0, '0);
		$display("Checks passed %0d, failed %0d, assertion failures %0d",
			pass_cnt, fail_cnt, dut_i.props_i.assert_fails);
		if (fail_cnt == 0 && dut_i.props_i.assert_fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/wph_properties.sv
// Write-port history timing properties
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_properties (
	input wire                  clk,
	input wire                  rst_n_i,
	input wire                  flush_i,
	input wire                  query_i,
	input wire [`WPH_NTAPS-1:0] hit_i,
	input wire                  hit_valid_i,
	input wire                  ready_i,
	input wire [`WPH_NTAPS-1:0] tap_valid_i
);

	// Failed assertions, read by the testbench at the end of the run
	int assert_fails = 0;

	// Every strobe is answered exactly one cycle later
	a_hit_valid_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
		query_i |=> hit_valid_i)
		else begin $error("hit_valid_o missing after query_i"); assert_fails++; end

	a_hit_valid_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		!query_i |=> !hit_valid_i)
		else begin $error("hit_valid_o without query_i"); assert_fails++; end

	a_hit_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
		!hit_valid_i |-> hit_i == '0)
		else begin $error("hit_o nonzero without hit_valid_o"); assert_fails++; end

	// ====================
	// Fill control
	// ====================

	a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> !ready_i)
		else begin $error("ready_o high after flush_i"); assert_fails++; end

	// Qualifiers only grow, except in the cycle that follows a flush
	a_tap_valid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		!flush_i |=> ((tap_valid_i & $past(tap_valid_i)) == $past(tap_valid_i)))
		else begin $error("tap_valid fell without flush"); assert_fails++; end

endmodule

bind wph_top wph_properties props_i (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.flush_i     (flush_i),
	.query_i     (query_i),
	.hit_i       (hit_o),
	.hit_valid_i (hit_valid_o),
	.ready_i     (ready_o),
	.tap_valid_i (ctrl_if.tap_valid)
);

`default_nettype wire

// File: hw/wph_top.sv
// Write-port history tracker top
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_top (
	input  wire                     clk,
	input  wire                     rst_n_i,
	// Writes of this cycle, one entry per register-file write port
	input  wire wph_pkg::wp_group_t wp_i,
	// Invalidates the whole recorded history
	input  wire                     flush_i,
	// Query strobe and the tag to look up
	input  wire                     query_i,
	input  wire [`WPH_TAG_W-1:0]    query_tag_i,
	// Per-tap hit mask, valid with hit_valid_o one cycle after the query
	output logic [`WPH_NTAPS-1:0]   hit_o,
	output logic                    hit_valid_o,
	// High once every tap holds post-flush writes
	output logic                    ready_o
);

	// Tap outputs of the shift line, indexed like hit_o
	wph_pkg::wp_group_t tap_w [`WPH_NTAPS];

	// Flush, timer and qualifier signals shared by the control path
	wph_ctrl_if ctrl_if ();

	// ====================
	// Control path
	// ====================

	wph_ctrl_fsm ctrl_fsm_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.flush_i (flush_i),
		.ctrl    (ctrl_if.fsm),
		.ready_o (ready_o)
	);

	wph_fill_timer fill_timer_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.ctrl    (ctrl_if.timer)
	);

	// ====================
	// Data path
	// ====================

	wph_history_tap history_tap_i (
		.clk   (clk),
		.wp_i  (wp_i),
		.tap_o (tap_w)
	);

	wph_tap_match tap_match_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ctrl        (ctrl_if.match),
		.tap_i       (tap_w),
		.query_i     (query_i),
		.query_tag_i (query_tag_i),
		.hit_o       (hit_o),
		.hit_valid_o (hit_valid_o)
	);

endmodule

`default_nettype wire

// File: hw/wph_tap_match.sv
// Tap query match stage
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_tap_match (
	input  wire                     clk,
	input  wire                     rst_n_i,
	wph_ctrl_if.match               ctrl,
	input  wire wph_pkg::wp_group_t tap_i [`WPH_NTAPS],
	input  wire                     query_i,
	input  wire [`WPH_TAG_W-1:0]    query_tag_i,
	output logic [`WPH_NTAPS-1:0]   hit_o,
	output logic                    hit_valid_o
);

	// Per-tap hit seen at the current edge, before registering
	logic [`WPH_NTAPS-1:0] hit_d;

	// ====================
	// Compare
	// ====================

	// A tap hits when any valid port in it wrote the queried tag
	// Ports with valid low are ignored even if their tag field matches
	always_comb
	begin
		hit_d = '0;
		for (int k = 0; k < `WPH_NTAPS; k++)
		begin
			for (int p = 0; p < `WPH_PORTS; p++)
			begin
				if (tap_i[k][p].valid && (tap_i[k][p].tag == query_tag_i))
					hit_d[k] = 1'b1;
			end
		end
		// Taps still holding pre-flush writes never report a hit
		hit_d = hit_d & ctrl.tap_valid;
	end

	// ====================
	// Response register
	// ====================

	// One answer per strobe, a cycle later, so back-to-back queries overlap
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			hit_valid_o <= 1'b0;
			hit_o       <= '0;
		end
		else
		begin
			hit_valid_o <= query_i;
			// Mask stays zero in cycles with no answer
			hit_o       <= query_i ? hit_d : '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/wph_history_tap.sv
// Write-port history shift line
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_history_tap (
	input  wire                clk,
	input  wire wph_pkg::wp_group_t wp_i,
	output wph_pkg::wp_group_t tap_o [`WPH_NTAPS]
);

	// Entry 0 is the newest group, entry WPH_DEPTH-1 the oldest
	wph_pkg::wp_group_t hist_q [`WPH_DEPTH];

	// ====================
	// Shift line
	// ====================

	// Every cycle's writes are recorded, even an all-invalid group
	// There is no clear, tap_valid hides whatever was here before a flush
	always_ff @(posedge clk)
	begin
		hist_q[0] <= wp_i;
		for (int i = 1; i < `WPH_DEPTH; i++)
			hist_q[i] <= hist_q[i-1];
	end

	// ====================
	// Tap points
	// ====================

	// At a sampling edge, entry d holds the group taken d+1 edges before
	assign tap_o[0] = hist_q[`WPH_TAP0];
	assign tap_o[1] = hist_q[`WPH_TAP1];
	assign tap_o[2] = hist_q[`WPH_TAP2];
	assign tap_o[3] = hist_q[`WPH_TAP3];
	// Deepest tap, the last entry of the line
	assign tap_o[4] = hist_q[`WPH_TAP4];

endmodule

`default_nettype wire

// File: hw/wph_fill_timer.sv
// Post-flush fill timer
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_fill_timer (
	input  wire        clk,
	input  wire        rst_n_i,
	wph_ctrl_if.timer  ctrl
);

	// Tap ages as counter values, indexed like the tap outputs
	localparam wph_pkg::fill_cnt_t TAP_AGE [`WPH_NTAPS] = '{
		wph_pkg::fill_cnt_t'(`WPH_TAP0),
		wph_pkg::fill_cnt_t'(`WPH_TAP1),
		wph_pkg::fill_cnt_t'(`WPH_TAP2),
		wph_pkg::fill_cnt_t'(`WPH_TAP3),
		wph_pkg::fill_cnt_t'(`WPH_TAP4)
	};

	// Cycles counted since the registered flush, held at WPH_FILL_MAX
	wph_pkg::fill_cnt_t count_q;

	// Cleared on the registered flush, then one step per cycle while run is high
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			count_q <= '0;
		else if (ctrl.flush)
			count_q <= '0;
		else if (ctrl.run && (count_q != wph_pkg::fill_cnt_t'(`WPH_FILL_MAX)))
			count_q <= count_q + 1'b1;
	end

	// ====================
	// Tap qualification
	// ====================

	// The count trails the flush edge by two cycles, so count >= age
	// is exactly the point where a tap holds its first post-flush group
	// While the registered flush is up every tap still holds stale writes
	always_comb
	begin
		for (int k = 0; k < `WPH_NTAPS; k++)
			ctrl.tap_valid[k] = !ctrl.flush && (count_q >= TAP_AGE[k]);
	end

	assign ctrl.done = (count_q == wph_pkg::fill_cnt_t'(`WPH_FILL_MAX));

endmodule

`default_nettype wire

// File: hw/wph_ctrl_fsm.sv
// History fill state machine
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

module wph_ctrl_fsm (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        flush_i,
	wph_ctrl_if.fsm    ctrl,
	output logic       ready_o
);

	wph_pkg::fill_state_t state_q;
	wph_pkg::fill_state_t state_d;
	logic                 flush_q;

	// ====================
	// Next state
	// ====================

	always_comb
	begin
		state_d = state_q;
		// A flush wins over every other transition
		if (flush_i)
		begin
			state_d = wph_pkg::FILL_EMPTY;
		end
		else
		begin
			case (state_q)
				// Single cycle here while the timer is being cleared
				wph_pkg::FILL_EMPTY: state_d = wph_pkg::FILL_RUN;
				// Wait for the timer to saturate, then every tap is live
				wph_pkg::FILL_RUN:   if (ctrl.done) state_d = wph_pkg::FILL_FULL;
				wph_pkg::FILL_FULL:  state_d = wph_pkg::FILL_FULL;
				default:             state_d = wph_pkg::FILL_EMPTY;
			endcase
		end
	end

	// ====================
	// State registers
	// ====================

	// Reset behaves like a flush, so the history starts out empty
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= wph_pkg::FILL_EMPTY;
			flush_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			flush_q <= flush_i;
		end
	end

	// The timer sees the flush one cycle later, in step with FILL_EMPTY
	assign ctrl.flush = flush_q;
	// Counting continues through FILL_FULL so the timer can hold saturation
	assign ctrl.run   = (state_q == wph_pkg::FILL_RUN) || (state_q == wph_pkg::FILL_FULL);
	assign ready_o    = (state_q == wph_pkg::FILL_FULL);

endmodule

`default_nettype wire

// File: hw/wph_ctrl_if.sv
// History fill control interface
`timescale 1ns/1ps
`default_nettype none

`include "wph_defines.svh"

interface wph_ctrl_if;

	// Registered flush pulse, one cycle after flush_i was sampled
	logic                  flush;
	// Timer enable, high while the history refills and once it is full
	logic                  run;
	// Timer has reached its saturation value
	logic                  done;
	// Per-tap qualifier, bit k set once tap k holds only post-flush writes
	logic [`WPH_NTAPS-1:0] tap_valid;

	// The FSM owns flush and run and watches for the timer to finish
	modport fsm (
		output flush,
		output run,
		input  done
	);

	// The timer counts under FSM control and qualifies the taps
	modport timer (
		input  flush,
		input  run,
		output done,
		output tap_valid
	);

	// The match stage only needs the tap qualifiers
	modport match (
		input  tap_valid
	);

endinterface

`default_nettype wire

// File: hw/wph_pkg.sv
// Write-port history types
`default_nettype none

`include "wph_defines.svh"

package wph_pkg;

	// ====================
	// Write-port payload
	// ====================

	// One register-file write port as seen by the history
	// Only the tag is tracked, the data value stays in the register file
	typedef struct packed {
		logic                  valid;
		logic [`WPH_TAG_W-1:0] tag;
	} wp_entry_t;

	// All writes made in one cycle, port 0 in the low bits
	typedef wp_entry_t [`WPH_PORTS-1:0] wp_group_t;

	// ====================
	// Fill control
	// ====================

	// Phases of the history after reset or flush
	// EMPTY lasts a single cycle, RUN covers the refill, FULL means every tap is live
	typedef enum logic [1:0] {
		FILL_EMPTY = 2'd0,
		FILL_RUN   = 2'd1,
		FILL_FULL  = 2'd2
	} fill_state_t;

	// Count of post-flush cycles held by the fill timer
	typedef logic [`WPH_CNT_W-1:0] fill_cnt_t;

endpackage

`default_nettype wire

// File: hw/wph_defines.svh
// Write-port history constants
`ifndef WPH_DEFINES_SVH
`define WPH_DEFINES_SVH

// ====================
// Write ports and tags
// ====================

// Register-file write ports sampled every cycle
`define WPH_PORTS 4
// Physical register tag width
`define WPH_TAG_W 8

// ====================
// History line
// ====================

// Entries in the shift line, the oldest tap sits at index WPH_DEPTH-1
`define WPH_DEPTH 101
// Number of tap points exposed to the match logic
`define WPH_NTAPS 5
// Tap ages, given as entry index into the history line
`define WPH_TAP0 3
`define WPH_TAP1 6
`define WPH_TAP2 12
`define WPH_TAP3 24
`define WPH_TAP4 100

// The fill timer saturates one past the deepest entry
`define WPH_FILL_MAX (`WPH_DEPTH + 1)
// Width of the fill counter, wide enough to hold WPH_FILL_MAX
`define WPH_CNT_W $clog2(`WPH_DEPTH + 2)

`endif
